//--- ntm_scalar_engine.f
+incdir+.
ntm_scalar_pkg.sv
ntm_scalar_op_if.sv
ntm_scalar_adder.sv
ntm_scalar_multiplier.sv
ntm_scalar_wb_regs.sv
ntm_scalar_engine.sv
ntm_scalar_properties.sv
ntm_scalar_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = ntm_scalar_tb
FILELIST = ntm_scalar_engine.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS     = ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run into $(LOG), check for the pass line"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@grep -q "$(PASS)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- ntm_scalar_tb.sv
`timescale 1ns/1ps
`include "ntm_scalar_macros.svh"

module ntm_scalar_tb import ntm_scalar_pkg::*; ();

  //////////////////////////////////////////////////////////////////////
  // Clock, reset and bus signals
  //////////////////////////////////////////////////////////////////////

  localparam int TIMEOUT_CYCLES = 40000;
  localparam int N_RAND         = 60;

  logic                      CLK;
  logic                      RST;
  logic                      wb_cyc;
  logic                      wb_stb;
  logic                      wb_we;
  logic [2:0]                wb_adr;
  logic [`NTM_DATA_SIZE-1:0] wb_wdata;
  logic [`NTM_DATA_SIZE-1:0] wb_rdata;
  logic                      wb_ack;
  int                        cycle_count = 0;

  ntm_scalar_engine uut (
    .CLK      (CLK),
    .RST      (RST),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack)
  );

  // 4 ns period
  always #2 CLK = ~CLK;

  //////////////////////////////////////////////////////////////////////
  // Failure handling and reference model
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error: %s expected 0x%08h actual 0x%08h", name, exp, act);
      abort_run("Readback did not match the model");
    end
  endtask

  // 64-bit reference model without reduction for a zero modulus
  function automatic logic [31:0] expected_result(input logic mul, input logic sub,
                                                  input logic [31:0] m, input logic [31:0] a,
                                                  input logic [31:0] b);
    logic [63:0] m64;
    logic [63:0] a64;
    logic [63:0] b64;
    logic [63:0] r64;
    m64 = {32'd0, m};
    a64 = {32'd0, a};
    b64 = {32'd0, b};
    if (mul) begin
      r64 = a64 * b64;
      if (m != 0) r64 = r64 % m64;
    end else if (!sub) begin
      r64 = a64 + b64;
      if (m != 0) r64 = r64 % m64;
    end else if (m == 0) begin
      // Absolute difference
      r64 = (a64 >= b64) ? (a64 - b64) : (b64 - a64);
    end else begin
      r64 = ((a64 % m64) + m64 - (b64 % m64)) % m64;
    end
    return r64[31:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Wishbone master and operation tasks
  //////////////////////////////////////////////////////////////////////

  // Strobe held through the edge that samples ack
  task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
    @(negedge CLK);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_wdata = data;
    @(negedge CLK);
    while (!wb_ack) @(negedge CLK);
    @(negedge CLK);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
    @(negedge CLK);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(negedge CLK);
    while (!wb_ack) @(negedge CLK);
    // Read data valid in the ack cycle
    data = wb_rdata;
    @(negedge CLK);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic start_op(input ntm_unit_e unit, input logic sub, input logic [31:0] m,
                          input logic [31:0] a, input logic [31:0] b);
    ntm_ctrl_u cmd;
    cmd.raw           = '0;
    cmd.cmd.start     = 1'b1;
    cmd.cmd.operation = sub;
    cmd.cmd.unit      = unit;
    wb_write(`NTM_ADR_MODULO, m);
    wb_write(`NTM_ADR_A, a);
    wb_write(`NTM_ADR_B, b);
    wb_write(`NTM_ADR_CTRL, cmd.raw);
  endtask

  // Poll status until done
  task automatic wait_done();
    ntm_ctrl_u st;
    st.raw = '0;
    while (!st.stat.done) wb_read(`NTM_ADR_CTRL, st.raw);
  endtask

  task automatic run_op(input string name, input ntm_unit_e unit, input logic sub,
                        input logic [31:0] m, input logic [31:0] a, input logic [31:0] b);
    logic [31:0] res;
    start_op(unit, sub, m, a, b);
    wait_done();
    wb_read(`NTM_ADR_RESULT, res);
    check_equal(name, expected_result(unit == NTM_UNIT_MUL, sub, m, a, b), res);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Timeout and assertion watch
  //////////////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run("Timeout: the tests did not finish within the cycle limit");
    end else if (uut.regs.props.error_count != 0) begin
      abort_run("A bus or handshake assertion failed");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] m;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rd;
    ntm_ctrl_u   cmd;
    void'($urandom(53455));
    CLK      = 1'b0;
    RST      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_wdata = '0;
    repeat (3) @(negedge CLK);
    RST = 1'b0;

    // Idle state after reset
    wb_read(`NTM_ADR_CTRL, rd);
    check_equal("reset_status", 32'd0, rd);
    wb_read(`NTM_ADR_RESULT, rd);
    check_equal("reset_result", 32'd0, rd);

    // Register readback
    m = $urandom;
    a = $urandom;
    b = $urandom;
    wb_write(`NTM_ADR_MODULO, m);
    wb_write(`NTM_ADR_A, a);
    wb_write(`NTM_ADR_B, b);
    wb_read(`NTM_ADR_MODULO, rd);
    check_equal("readback_modulo", m, rd);
    wb_read(`NTM_ADR_A, rd);
    check_equal("readback_a", a, rd);
    wb_read(`NTM_ADR_B, rd);
    check_equal("readback_b", b, rd);

    // Modular add with some sums landing exactly on M
    for (int i = 0; i < N_RAND; i++) begin
      m = $urandom | 32'h8000_0000;
      a = $urandom;
      b = $urandom;
      if (i % 6 == 0) begin
        a = $urandom % m;
        b = m - a;
      end
      run_op("mod_add", NTM_UNIT_ADD, 1'b0, m, a, b);
    end

    // Modular subtract with equal, swapped and zero-modulus cases
    for (int i = 0; i < N_RAND; i++) begin
      m = $urandom | 32'h8000_0000;
      a = $urandom;
      b = $urandom;
      if (i % 5 == 0) b = a;
      if ((i % 5 == 1) && (a > b)) begin
        rd = a;
        a  = b;
        b  = rd;
      end
      if (i % 5 == 2) m = '0;
      run_op("mod_sub", NTM_UNIT_ADD, 1'b1, m, a, b);
    end

    // Modular multiply with some zero-modulus cases
    for (int i = 0; i < N_RAND; i++) begin
      m = $urandom | 32'h8000_0000;
      a = $urandom;
      b = $urandom;
      if (i % 6 == 0) m = '0;
      run_op("mod_mul", NTM_UNIT_MUL, 1'b0, m, a, b);
    end

    // Command and operand writes while a multiply runs
    m = 32'hFFFF_FFFB;
    a = 32'h1234_5678;
    b = 32'h9ABC_DEF0;
    start_op(NTM_UNIT_MUL, 1'b0, m, a, b);
    wb_write(`NTM_ADR_A, 32'hDEAD_BEEF);
    cmd.raw       = '0;
    cmd.cmd.start = 1'b1;
    cmd.cmd.unit  = NTM_UNIT_ADD;
    wb_write(`NTM_ADR_CTRL, cmd.raw);
    wb_read(`NTM_ADR_CTRL, rd);
    check_equal("busy_status", 32'd1, rd);
    wait_done();
    wb_read(`NTM_ADR_RESULT, rd);
    check_equal("busy_result", expected_result(1'b1, 1'b0, m, a, b), rd);
    wb_read(`NTM_ADR_CTRL, rd);
    check_equal("busy_done", 32'd2, rd);

    repeat (4) @(negedge CLK);
    if (uut.regs.props.error_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      abort_run("A bus or handshake assertion failed");
    end
  end

endmodule

//--- ntm_scalar_properties.sv
`timescale 1ns/1ps

module ntm_scalar_properties (
  input logic CLK,
  input logic RST,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic add_start,
  input logic mul_start,
  input logic add_ready,
  input logic mul_ready,
  input logic busy,
  input logic done
);

  // Failures so far, watched from the testbench
  int error_count = 0;

  //////////////////////////////////////////////////////////////////////
  // Wishbone slave side
  //////////////////////////////////////////////////////////////////////

  // Ack only inside an active cycle
  ack_in_strobe: assert property (@(posedge CLK) disable iff (RST)
    wb_ack |-> (wb_cyc && wb_stb))
    else begin
      error_count++;
      $error("wb_ack high without wb_cyc and wb_stb");
    end

  // Single-cycle ack
  ack_one_cycle: assert property (@(posedge CLK) disable iff (RST)
    wb_ack |=> !wb_ack)
    else begin
      error_count++;
      $error("wb_ack held for two cycles");
    end

  //////////////////////////////////////////////////////////////////////
  // Unit handshake
  //////////////////////////////////////////////////////////////////////

  // busy rises with start, so look one cycle back
  start_when_idle: assert property (@(posedge CLK) disable iff (RST)
    (add_start || mul_start) |-> !$past(busy))
    else begin
      error_count++;
      $error("start pulsed while an operation was outstanding");
    end

  ready_sets_done: assert property (@(posedge CLK) disable iff (RST)
    (add_ready || mul_ready) |=> done)
    else begin
      error_count++;
      $error("done not set in the cycle after ready");
    end

endmodule

bind ntm_scalar_wb_regs ntm_scalar_properties props (
  .CLK       (CLK),
  .RST       (RST),
  .wb_cyc    (wb_cyc),
  .wb_stb    (wb_stb),
  .wb_ack    (wb_ack),
  .add_start (add_start),
  .mul_start (mul_start),
  .add_ready (add_bus.ready),
  .mul_ready (mul_bus.ready),
  .busy      (busy),
  .done      (done)
);

//--- ntm_scalar_engine.sv
`timescale 1ns/1ps
`include "ntm_scalar_macros.svh"

module ntm_scalar_engine (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [2:0]                wb_adr,
  input  logic [`NTM_DATA_SIZE-1:0] wb_wdata,
  output logic [`NTM_DATA_SIZE-1:0] wb_rdata,
  output logic                      wb_ack
);

  //////////////////////////////////////////////////////////////////////
  // Unit links
  //////////////////////////////////////////////////////////////////////

  ntm_scalar_op_if #(.DATA_SIZE(`NTM_DATA_SIZE)) add_bus ();
  ntm_scalar_op_if #(.DATA_SIZE(`NTM_DATA_SIZE)) mul_bus ();

  // Wishbone front end
  ntm_scalar_wb_regs regs (
    .CLK      (CLK),
    .RST      (RST),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack),
    .add_bus  (add_bus.requester),
    .mul_bus  (mul_bus.requester)
  );

  // Add and subtract
  ntm_scalar_adder #(.DATA_SIZE(`NTM_DATA_SIZE)) adder (
    .CLK (CLK),
    .RST (RST),
    .op  (add_bus.unit)
  );

  // Multiply
  ntm_scalar_multiplier #(.DATA_SIZE(`NTM_DATA_SIZE)) multiplier (
    .CLK (CLK),
    .RST (RST),
    .op  (mul_bus.unit)
  );

endmodule

//--- ntm_scalar_wb_regs.sv
`timescale 1ns/1ps
`include "ntm_scalar_macros.svh"

module ntm_scalar_wb_regs import ntm_scalar_pkg::*; (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [2:0]                wb_adr,
  input  logic [`NTM_DATA_SIZE-1:0] wb_wdata,
  output logic [`NTM_DATA_SIZE-1:0] wb_rdata,
  output logic                      wb_ack,
  ntm_scalar_op_if.requester        add_bus,
  ntm_scalar_op_if.requester        mul_bus
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  logic                      wb_req;
  logic                      wr_en;
  logic                      ctrl_wr;
  logic                      cmd_go;
  ntm_ctrl_u                 cmd_word;
  ntm_ctrl_u                 stat_word;
  logic [`NTM_DATA_SIZE-1:0] modulo_q;
  logic [`NTM_DATA_SIZE-1:0] data_a_q;
  logic [`NTM_DATA_SIZE-1:0] data_b_q;
  logic [`NTM_DATA_SIZE-1:0] result_q;
  logic                      operation_q;
  logic                      busy;
  logic                      done;
  logic                      add_start;
  logic                      mul_start;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  // New access only when no ack in flight
  assign wb_req   = wb_cyc & wb_stb & ~wb_ack;
  assign wr_en    = wb_req & wb_we;
  assign ctrl_wr  = wr_en && (wb_adr == `NTM_ADR_CTRL);

  // Write data viewed as a command
  assign cmd_word.raw = wb_wdata;

  // Start accepted only when idle
  assign cmd_go = ctrl_wr && cmd_word.cmd.start && !busy;

  // Status view for readback
  always_comb begin
    stat_word.raw       = '0;
    stat_word.stat.busy = busy;
    stat_word.stat.done = done;
  end

  //////////////////////////////////////////////////////////////////////
  // Bus response
  //////////////////////////////////////////////////////////////////////

  // Single-cycle ack, read data valid with it
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wb_ack   <= 1'b0;
      wb_rdata <= '0;
    end else begin
      wb_ack <= wb_req;
      if (wb_req && !wb_we) begin
        case (wb_adr)
          `NTM_ADR_CTRL:   wb_rdata <= stat_word.raw;
          `NTM_ADR_MODULO: wb_rdata <= modulo_q;
          `NTM_ADR_A:      wb_rdata <= data_a_q;
          `NTM_ADR_B:      wb_rdata <= data_b_q;
          `NTM_ADR_RESULT: wb_rdata <= result_q;
          default:         wb_rdata <= '0;
        endcase
      end
    end
  end

  // Operand registers
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      modulo_q <= '0;
      data_a_q <= '0;
      data_b_q <= '0;
    end else if (wr_en) begin
      case (wb_adr)
        `NTM_ADR_MODULO: modulo_q <= wb_wdata;
        `NTM_ADR_A:      data_a_q <= wb_wdata;
        `NTM_ADR_B:      data_b_q <= wb_wdata;
        default:         ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Command and completion
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      add_start   <= 1'b0;
      mul_start   <= 1'b0;
      operation_q <= 1'b0;
      busy        <= 1'b0;
      done        <= 1'b0;
      result_q    <= '0;
    end else begin
      // Start pulse lands in the ack cycle
      add_start <= cmd_go && (cmd_word.cmd.unit == NTM_UNIT_ADD);
      mul_start <= cmd_go && (cmd_word.cmd.unit == NTM_UNIT_MUL);
      if (cmd_go) begin
        operation_q <= cmd_word.cmd.operation;
        busy        <= 1'b1;
      end
      // Any command write clears done
      if (ctrl_wr) begin
        done <= 1'b0;
      end
      // Completion wins over a concurrent write
      if (add_bus.ready || mul_bus.ready) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
      if (add_bus.ready) begin
        result_q <= add_bus.result;
      end else if (mul_bus.ready) begin
        result_q <= mul_bus.result;
      end
    end
  end

  // Adder request
  assign add_bus.start     = add_start;
  assign add_bus.operation = operation_q;
  assign add_bus.modulo    = modulo_q;
  assign add_bus.data_a    = data_a_q;
  assign add_bus.data_b    = data_b_q;

  // Multiplier request, no operation select
  assign mul_bus.start     = mul_start;
  assign mul_bus.operation = NTM_OP_ADD;
  assign mul_bus.modulo    = modulo_q;
  assign mul_bus.data_a    = data_a_q;
  assign mul_bus.data_b    = data_b_q;

endmodule

//--- ntm_scalar_multiplier.sv
`timescale 1ns/1ps
`include "ntm_scalar_macros.svh"

module ntm_scalar_multiplier #(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input  logic       CLK,
  input  logic       RST,
  ntm_scalar_op_if.unit op
);

  //////////////////////////////////////////////////////////////////////
  // States and signals
  //////////////////////////////////////////////////////////////////////

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_PRE  = 2'd1;
  localparam logic [1:0] ST_STEP = 2'd2;
  localparam logic [1:0] ST_DONE = 2'd3;

  // Bit counter width
  localparam int CW = $clog2(DATA_SIZE + 1);

  logic [1:0]           state;
  logic [CW-1:0]        count;
  logic                 ready_q;
  logic [DATA_SIZE-1:0] modulo_q;
  logic [DATA_SIZE-1:0] a_q;
  logic [DATA_SIZE-1:0] b_q;
  logic [DATA_SIZE-1:0] acc_q;
  logic [DATA_SIZE-1:0] result_q;

  logic                 start_pre;
  logic [DATA_SIZE-1:0] a_sub;
  logic                 pre_more;
  logic [DATA_SIZE-1:0] addend;
  // Up to 3M before reduction
  logic [DATA_SIZE+1:0] step_raw;
  logic [DATA_SIZE+1:0] step_1;
  logic [DATA_SIZE+1:0] step_2;
  logic [DATA_SIZE+1:0] modulo_ext;
  logic [DATA_SIZE-1:0] step_next;

  //////////////////////////////////////////////////////////////////////
  // Combinational datapath
  //////////////////////////////////////////////////////////////////////

  // Pre-reduction needed only if A >= M
  assign start_pre = (op.modulo != '0) && (op.data_a >= op.modulo);
  assign a_sub     = a_q - modulo_q;
  assign pre_more  = a_sub >= modulo_q;

  assign modulo_ext = {2'b00, modulo_q};
  // MSB of B picks the add
  assign addend     = b_q[DATA_SIZE-1] ? a_q : '0;

  always_comb begin
    step_raw = {1'b0, acc_q, 1'b0} + {2'b00, addend};
    step_1   = (step_raw >= modulo_ext) ? (step_raw - modulo_ext) : step_raw;
    step_2   = (step_1 >= modulo_ext) ? (step_1 - modulo_ext) : step_1;
    if (modulo_q == '0) begin
      // Truncated product
      step_next = step_raw[DATA_SIZE-1:0];
    end else begin
      step_next = step_2[DATA_SIZE-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= ST_IDLE;
      count   <= '0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (op.start) begin
            state <= start_pre ? ST_PRE : ST_STEP;
            count <= CW'(DATA_SIZE - 1);
          end
        end
        ST_PRE: begin
          if (!pre_more) begin
            state <= ST_STEP;
          end
        end
        ST_STEP: begin
          count <= count - 1'b1;
          if (count == '0) begin
            state <= ST_DONE;
          end
        end
        default: begin
          state   <= ST_IDLE;
          ready_q <= 1'b1;
        end
      endcase
    end
  end

  // Operands, accumulator and result
  always_ff @(posedge CLK) begin
    case (state)
      ST_IDLE: begin
        if (op.start) begin
          modulo_q <= op.modulo;
          a_q      <= op.data_a;
          b_q      <= op.data_b;
          acc_q    <= '0;
        end
      end
      ST_PRE:  a_q <= a_sub;
      ST_STEP: begin
        // Double and add, B walked MSB first
        acc_q <= step_next;
        b_q   <= b_q << 1;
      end
      default: result_q <= acc_q;
    endcase
  end

  assign op.ready  = ready_q;
  assign op.result = result_q;

endmodule

//--- ntm_scalar_adder.sv
`timescale 1ns/1ps
`include "ntm_scalar_macros.svh"

module ntm_scalar_adder import ntm_scalar_pkg::*; #(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) (
  input  logic       CLK,
  input  logic       RST,
  ntm_scalar_op_if.unit op
);

  //////////////////////////////////////////////////////////////////////
  // States and signals
  //////////////////////////////////////////////////////////////////////

  localparam logic ST_IDLE   = 1'b0;
  localparam logic ST_REDUCE = 1'b1;

  logic                 state;
  logic                 ready_q;
  logic                 negative_q;
  logic [DATA_SIZE-1:0] modulo_q;
  logic [DATA_SIZE:0]   value_q;
  logic [DATA_SIZE-1:0] result_q;

  // Raw sum and difference with guard bit
  logic [DATA_SIZE:0]   sum;
  logic [DATA_SIZE:0]   diff;
  logic [DATA_SIZE:0]   abs_diff;
  logic [DATA_SIZE:0]   modulo_ext;
  logic                 finish;
  logic [DATA_SIZE-1:0] final_val;

  //////////////////////////////////////////////////////////////////////
  // Combinational datapath
  //////////////////////////////////////////////////////////////////////

  assign sum  = {1'b0, op.data_a} + {1'b0, op.data_b};
  assign diff = {1'b0, op.data_a} - {1'b0, op.data_b};

  // Guard bit set means B was larger
  assign abs_diff = diff[DATA_SIZE] ? (~diff + 1'b1) : diff;

  assign modulo_ext = {1'b0, modulo_q};

  // Stop once value fits or no modulus
  assign finish = (modulo_q == '0) || (value_q <= modulo_ext);

  always_comb begin
    if (modulo_q == '0) begin
      // Plain sum or absolute difference
      final_val = value_q[DATA_SIZE-1:0];
    end else if ((value_q == modulo_ext) || (value_q == '0)) begin
      final_val = '0;
    end else if (negative_q) begin
      // Fold negative result into range
      final_val = modulo_q - value_q[DATA_SIZE-1:0];
    end else begin
      final_val = value_q[DATA_SIZE-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= ST_IDLE;
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (op.start) begin
            state <= ST_REDUCE;
          end
        end
        default: begin
          if (finish) begin
            state   <= ST_IDLE;
            ready_q <= 1'b1;
          end
        end
      endcase
    end
  end

  // Operand capture and reduction loop
  always_ff @(posedge CLK) begin
    if (state == ST_IDLE) begin
      if (op.start) begin
        modulo_q   <= op.modulo;
        negative_q <= (op.operation == NTM_OP_SUB) && diff[DATA_SIZE];
        value_q    <= (op.operation == NTM_OP_SUB) ? abs_diff : sum;
      end
    end else if (finish) begin
      result_q <= final_val;
    end else begin
      // One modulus per cycle
      value_q <= value_q - modulo_ext;
    end
  end

  assign op.ready  = ready_q;
  assign op.result = result_q;

endmodule

//--- ntm_scalar_op_if.sv
`timescale 1ns/1ps
`include "ntm_scalar_macros.svh"

interface ntm_scalar_op_if #(
  parameter int DATA_SIZE = `NTM_DATA_SIZE
) ();

  // Request side
  logic                 start;
  logic                 operation;
  logic [DATA_SIZE-1:0] modulo;
  logic [DATA_SIZE-1:0] data_a;
  logic [DATA_SIZE-1:0] data_b;

  // Completion side
  logic                 ready;
  logic [DATA_SIZE-1:0] result;

  // Register block issues the operation
  modport requester (
    output start,
    output operation,
    output modulo,
    output data_a,
    output data_b,
    input  ready,
    input  result
  );

  // Arithmetic unit answers with ready and result
  modport unit (
    input  start,
    input  operation,
    input  modulo,
    input  data_a,
    input  data_b,
    output ready,
    output result
  );

endinterface

//--- ntm_scalar_pkg.sv
`include "ntm_scalar_macros.svh"

package ntm_scalar_pkg;

  // Operation bit as seen by the adder
  localparam logic NTM_OP_ADD = 1'b0;
  localparam logic NTM_OP_SUB = 1'b1;

  // Target unit of a command
  typedef enum logic {
    NTM_UNIT_ADD = 1'b0,
    NTM_UNIT_MUL = 1'b1
  } ntm_unit_e;

  // Control word as written by the host
  typedef struct packed {
    logic [`NTM_DATA_SIZE-4:0] pad;
    ntm_unit_e                 unit;
    logic                      operation;
    logic                      start;
  } ntm_ctrl_cmd_t;

  // Control word as read back
  typedef struct packed {
    logic [`NTM_DATA_SIZE-3:0] pad;
    logic                      done;
    logic                      busy;
  } ntm_ctrl_stat_t;

  // Same address, command on write and status on read
  typedef union packed {
    logic [`NTM_DATA_SIZE-1:0] raw;
    ntm_ctrl_cmd_t             cmd;
    ntm_ctrl_stat_t            stat;
  } ntm_ctrl_u;

endpackage

//--- ntm_scalar_macros.svh
`ifndef NTM_SCALAR_MACROS_SVH
`define NTM_SCALAR_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath width
//////////////////////////////////////////////////////////////////////

// Operand, modulus and result width
`define NTM_DATA_SIZE 32

//////////////////////////////////////////////////////////////////////
// Register map
//////////////////////////////////////////////////////////////////////

// Word addresses on the 3-bit bus
`define NTM_ADR_CTRL   3'd0
`define NTM_ADR_MODULO 3'd1
`define NTM_ADR_A      3'd2
`define NTM_ADR_B      3'd3
`define NTM_ADR_RESULT 3'd4

`endif
